//--- bench/nfc_emulation_tb.sv
`timescale 1ns/1ns

`include "iso14443_consts.svh"

module nfc_emulation_tb import iso14443_pkg::*; ();

    // ==============================
    // timing of the reader model
    // ==============================

    localparam int WIN         = `ISO_BIT_TICKS;
    localparam int PAUSE_LEN   = 32;
    localparam int BAD_OFFSET  = 40;
    localparam int GAP_WINDOWS = 4;
    localparam int LOSS_HOLD   = 400;
    // the LOST handshake needs up to 13 cycles with an 8 cycle ack delay
    localparam int LOCK_DROP   = 16;

    // one frame of the table
    typedef struct packed {
        int          nbits;
        logic [15:0] bits;
        logic        corrupt;
    } frame_t;

    logic       clk_13p56_tmp;
    logic       rst_n;
    logic       pause_n;
    logic       clk_locked;
    logic       clk_13p56_en;
    logic       card_rst_n;
    logic       rx_req;
    logic       rx_ack;
    rx_item_t   rx_data;
    logic       evt_req;
    logic       evt_ack;
    field_evt_t evt_data;

    string      test_names[$];
    frame_t     tests[$];
    rx_item_t   rx_exp[$];
    string      rx_exp_name[$];
    field_evt_t evt_exp[$];
    string      evt_exp_name[$];
    string      cur_test;
    int         mismatches = 0;
    int         failures = 0;
    integer     seed = 32'h6b1c_4478;
    bit         en_check_on = 1'b0;
    // pause_n as driven after the last three edges
    logic [2:0] pause_hist = 3'b111;

    nfc_emulation_top DUT (
        .clk_13p56_tmp (clk_13p56_tmp),
        .rst_n         (rst_n),
        .pause_n       (pause_n),
        .clk_locked    (clk_locked),
        .clk_13p56_en  (clk_13p56_en),
        .card_rst_n    (card_rst_n),
        .rx_req        (rx_req),
        .rx_ack        (rx_ack),
        .rx_data       (rx_data),
        .evt_req       (evt_req),
        .evt_ack       (evt_ack),
        .evt_data      (evt_data)
    );

    initial begin
        clk_13p56_tmp = 1'b0;
        forever #10 clk_13p56_tmp = ~clk_13p56_tmp;
    end

    // ==============================
    // table and expected items
    // ==============================

    task automatic add_test(input string name, input int nbits, input logic [15:0] bits,
                            input logic corrupt);
        frame_t f;
        f.nbits   = nbits;
        f.bits    = bits;
        f.corrupt = corrupt;
        test_names.push_back(name);
        tests.push_back(f);
    endtask

    task automatic expect_rx(input rx_kind_e kind, input logic value);
        rx_item_t it;
        it.kind  = kind;
        it.value = value;
        rx_exp.push_back(it);
        rx_exp_name.push_back(cur_test);
    endtask

    task automatic expect_evt(input field_evt_e e);
        field_evt_t ev;
        ev.evt = e;
        evt_exp.push_back(ev);
        evt_exp_name.push_back(cur_test);
    endtask

    // a good frame gives SOF, its bits in order and EOF
    // a bad pause gives SOF then ERR
    task automatic expect_frame(input frame_t f);
        int          i;
        logic [15:0] bits;
        bits = f.bits;
        expect_rx(RX_SOF, 1'b0);
        if (f.corrupt) begin
            expect_rx(RX_ERR, 1'b0);
        end else begin
            for (i = 0; i < f.nbits; i++) begin
                expect_rx(RX_BIT, bits[0]);
                bits = bits >> 1;
            end
            expect_rx(RX_EOF, 1'b0);
        end
    endtask

    // ==============================
    // reader pause model
    // ==============================

    // one bit window with a pause of PAUSE_LEN ticks from offset
    task automatic drive_window(input bit has_pause, input int offset);
        int t;
        for (t = 0; t < WIN; t++) begin
            @(posedge clk_13p56_tmp);
            #2;
            pause_n = !(has_pause && (t >= offset) && (t < offset + PAUSE_LEN));
        end
    endtask

    task automatic idle_windows(input int n);
        repeat (n) drive_window(1'b0, 0);
    endtask

    task automatic send_frame(input frame_t f);
        int          i;
        logic        prev_one;
        logic [15:0] bits;
        bits     = f.bits;
        prev_one = 1'b0;
        // start of communication is a Z
        drive_window(1'b1, 0);
        if (f.corrupt) begin
            drive_window(1'b1, BAD_OFFSET);
        end else begin
            for (i = 0; i < f.nbits; i++) begin
                if (bits[0]) begin
                    // X has its pause mid window
                    drive_window(1'b1, `ISO_HALF_TICKS);
                end else begin
                    // Y after a 1 and Z otherwise
                    drive_window(!prev_one, 0);
                end
                prev_one = bits[0];
                bits     = bits >> 1;
            end
            // end of frame is a 0 then a Y
            drive_window(!prev_one, 0);
            drive_window(1'b0, 0);
        end
        idle_windows(GAP_WINDOWS);
    endtask

    // waits until every expected item has arrived
    task automatic drain_queues();
        while ((rx_exp.size() != 0) || (evt_exp.size() != 0)) begin
            @(posedge clk_13p56_tmp);
        end
    endtask

    task automatic print_counts();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    endtask

    // readable form of an rx item for error lines
    function automatic string item_text(input rx_item_t it);
        return $sformatf("kind %s value %0d", it.kind.name(), it.value);
    endfunction

    // ==============================
    // ack responders
    // ==============================

    initial begin : rx_responder
        int       dly;
        rx_item_t exp;
        string    nm;
        rx_ack = 1'b0;
        forever begin
            @(negedge clk_13p56_tmp);
            if (rx_req) begin
                if (rx_exp.size() == 0) begin
                    failures++;
                    $display("rx item %s arrived with none expected", item_text(rx_data));
                end else begin
                    exp = rx_exp.pop_front();
                    nm  = rx_exp_name.pop_front();
                    if (rx_data !== exp) begin
                        mismatches++;
                        $display("MISMATCH %s rx item: expected %s, actual %s",
                                 nm, item_text(exp), item_text(rx_data));
                    end
                end
                dly = ($random(seed) & 7) + 1;
                repeat (dly) @(posedge clk_13p56_tmp);
                #2 rx_ack = 1'b1;
                @(negedge clk_13p56_tmp);
                while (rx_req) @(negedge clk_13p56_tmp);
                @(posedge clk_13p56_tmp);
                #2 rx_ack = 1'b0;
            end
        end
    end

    initial begin : evt_responder
        int         dly;
        field_evt_t exp;
        string      nm;
        evt_ack = 1'b0;
        forever begin
            @(negedge clk_13p56_tmp);
            if (evt_req) begin
                if (evt_exp.size() == 0) begin
                    failures++;
                    $display("field event %0d arrived with none expected", evt_data.evt);
                end else begin
                    exp = evt_exp.pop_front();
                    nm  = evt_exp_name.pop_front();
                    if (evt_data !== exp) begin
                        mismatches++;
                        $display("MISMATCH %s field event: expected %0d, actual %0d",
                                 nm, exp.evt, evt_data.evt);
                    end
                end
                dly = ($random(seed) & 7) + 1;
                repeat (dly) @(posedge clk_13p56_tmp);
                #2 evt_ack = 1'b1;
                @(negedge clk_13p56_tmp);
                while (evt_req) @(negedge clk_13p56_tmp);
                @(posedge clk_13p56_tmp);
                #2 evt_ack = 1'b0;
            end
        end
    end

    // clock enable is pause_n three edges late
    always @(negedge clk_13p56_tmp) begin
        if (en_check_on && (clk_13p56_en !== pause_hist[2])) begin
            mismatches++;
            $display("MISMATCH %s clk_13p56_en: expected %0b, actual %0b",
                     cur_test, pause_hist[2], clk_13p56_en);
        end
        pause_hist = {pause_hist[1:0], pause_n};
    end

    // ==============================
    // watchdog
    // ==============================

    initial begin : watchdog
        int i;
        int total_windows;
        int limit_ns;
        // table is filled at time 0
        #1;
        total_windows = 0;
        for (i = 0; i < tests.size(); i++) begin
            total_windows += tests[i].corrupt ? (2 + GAP_WINDOWS)
                                              : (3 + tests[i].nbits + GAP_WINDOWS);
        end
        // field loss hold with its gap and then the lock drop
        total_windows += LOSS_HOLD / WIN + 1 + GAP_WINDOWS + 1;
        limit_ns = (total_windows * WIN + 2000) * 20;
        #(limit_ns);
        $display("watchdog timeout, items still expected");
        print_counts();
        $display("STATUS: FAIL");
        $finish;
    end

    // ==============================
    // test sequence
    // ==============================

    initial begin : main_seq
        int i;
        rst_n      = 1'b0;
        pause_n    = 1'b1;
        clk_locked = 1'b1;
        cur_test   = "reset";

        add_test("mixed_short",     4,  16'h0009, 1'b0);
        add_test("mixed_trailing0", 8,  16'h0035, 1'b0);
        add_test("all_ones",        7,  16'h007f, 1'b0);
        add_test("all_zeros",       5,  16'h0000, 1'b0);
        add_test("alternating",     16, 16'h5555, 1'b0);
        add_test("corrupt_offset",  4,  16'h000b, 1'b1);
        add_test("after_corrupt",   9,  16'h01a6, 1'b0);

        // first READY comes once the clock is locked with the carrier on
        expect_evt(EVT_FIELD_READY);
        repeat (2) @(posedge clk_13p56_tmp);
        #2;
        if (card_rst_n !== 1'b0) begin
            failures++;
            $display("card_rst_n was not low during reset");
        end
        if (clk_13p56_en !== 1'b0) begin
            failures++;
            $display("clk_13p56_en was not low during reset");
        end
        if ((rx_req !== 1'b0) || (evt_req !== 1'b0)) begin
            failures++;
            $display("a req output was not low during reset");
        end
        rst_n = 1'b1;
        drain_queues();
        repeat (4) @(posedge clk_13p56_tmp);
        #2;
        if (card_rst_n !== 1'b1) begin
            failures++;
            $display("card_rst_n did not rise after reset with the clock locked");
        end
        en_check_on = 1'b1;

        // frames from the table
        for (i = 0; i < tests.size(); i++) begin
            cur_test = test_names[i];
            expect_frame(tests[i]);
            send_frame(tests[i]);
            drain_queues();
        end

        // field gone too long
        cur_test = "field_loss";
        // the first falling edge is taken as a start of communication
        // card reset lands on the same edge as the following Y
        expect_rx(RX_SOF, 1'b0);
        expect_evt(EVT_FIELD_LOST);
        expect_evt(EVT_FIELD_READY);
        repeat (LOSS_HOLD) begin
            @(posedge clk_13p56_tmp);
            #2;
            pause_n = 1'b0;
        end
        if (card_rst_n !== 1'b0) begin
            failures++;
            $display("card_rst_n was not low after the field was gone for %0d ticks",
                     LOSS_HOLD);
        end
        idle_windows(GAP_WINDOWS);
        drain_queues();
        if (card_rst_n !== 1'b1) begin
            failures++;
            $display("card_rst_n did not recover after the field returned");
        end

        // clock source loses lock
        cur_test = "lock_drop";
        expect_evt(EVT_FIELD_LOST);
        expect_evt(EVT_FIELD_READY);
        @(posedge clk_13p56_tmp);
        #2;
        clk_locked = 1'b0;
        repeat (LOCK_DROP) begin
            @(posedge clk_13p56_tmp);
            #2;
            if (card_rst_n !== 1'b0) begin
                failures++;
                $display("card_rst_n was high while clk_locked was low");
            end
        end
        clk_locked = 1'b1;
        drain_queues();
        repeat (4) @(posedge clk_13p56_tmp);
        #2;
        if (card_rst_n !== 1'b1) begin
            failures++;
            $display("card_rst_n did not recover after the clock locked again");
        end

        en_check_on = 1'b0;
        print_counts();
        if ((mismatches + failures) == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- include/iso14443_consts.svh
`ifndef ISO14443_CONSTS_SVH
`define ISO14443_CONSTS_SVH

// ==============================
// bit window timing
// ==============================

// 13.56 MHz ticks per bit window (fc/128)
`define ISO_BIT_TICKS 128
// nominal offset of the pause for a sequence X
`define ISO_HALF_TICKS 64

// pause start offsets, in ticks from the window start
// sequence Z: pause near the start of the window
`define ISO_Z_WIN_MAX 31
// sequence X: pause around the middle of the window
`define ISO_X_WIN_MIN 48
`define ISO_X_WIN_MAX 79

// ==============================
// field supervision
// ==============================

// low ticks on pause_sync before the field counts as gone (two bit windows)
`define ISO_FIELD_LOSS_TICKS 255

`endif

//--- nfc_emulation_top.f
+incdir+include
source/iso14443_pkg.sv
source/field_reset_ctrl.sv
source/miller_symbol_detect.sv
source/miller_frame_decode.sv
source/four_phase_tx.sv
source/nfc_emulation_top.sv
bench/nfc_emulation_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --timescale 1ns/1ns \
    --top-module nfc_emulation_tb \
    -f nfc_emulation_top.f \
    -o nfc_emulation_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed"
    exit 1
fi

./obj_dir/nfc_emulation_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "STATUS: PASS" "$SIM_LOG"; then
    exit 0
fi
exit 1

//--- source/field_reset_ctrl.sv
`timescale 1ns/1ns

`include "iso14443_consts.svh"

module field_reset_ctrl import iso14443_pkg::*; (
    input  logic       clk_13p56_tmp,
    input  logic       rst_n,
    input  logic       pause_n,
    input  logic       clk_locked,
    output logic       pause_sync,
    output logic       clk_13p56_en,
    output logic       card_rst_n,
    output logic       evt_push,
    output field_evt_t evt_data
);

    localparam logic [7:0] LOSS_MAX = 8'(`ISO_FIELD_LOSS_TICKS);

    logic       pause_meta;
    logic [7:0] loss_cnt;
    logic       card_rst_nxt;

    // ==============================
    // pause_n synchroniser
    // ==============================

    // idles high, no pause means carrier present
    always_ff @(posedge clk_13p56_tmp or negedge rst_n) begin
        if (!rst_n) begin
            pause_meta <= 1'b1;
            pause_sync <= 1'b1;
        end else begin
            pause_meta <= pause_n;
            pause_sync <= pause_meta;
        end
    end

    // ==============================
    // clock enable and card reset
    // ==============================

    // card held in reset when the field has been gone too long
    // or the clock source is not locked
    assign card_rst_nxt = !((loss_cnt == LOSS_MAX) || !clk_locked);

    always_ff @(posedge clk_13p56_tmp or negedge rst_n) begin
        if (!rst_n) begin
            clk_13p56_en <= 1'b0;
            loss_cnt     <= 8'd0;
            card_rst_n   <= 1'b0;
            evt_push     <= 1'b0;
        end else begin
            // card clock only runs while the carrier is on
            clk_13p56_en <= pause_sync;

            // saturating count of low ticks, cleared by any high tick
            if (pause_sync) begin
                loss_cnt <= 8'd0;
            end else if (loss_cnt != LOSS_MAX) begin
                loss_cnt <= loss_cnt + 8'd1;
            end

            card_rst_n <= card_rst_nxt;
            // one push per reset edge, lands with the new card_rst_n level
            evt_push   <= (card_rst_nxt != card_rst_n);
        end
    end

    // event kind follows the current reset level
    // falling edge gives LOST, rising edge gives READY
    assign evt_data.evt = card_rst_n ? EVT_FIELD_READY : EVT_FIELD_LOST;

endmodule

//--- source/four_phase_tx.sv
`timescale 1ns/1ns

module four_phase_tx #(
    parameter type payload_t = logic
) (
    input  logic     clk_13p56_tmp,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    output logic     req,
    input  logic     ack,
    output payload_t data
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_ACK_HI,
        ST_WAIT_ACK_LO
    } tx_state_e;

    tx_state_e state;

    // ==============================
    // handshake FSM
    // ==============================

    // idle -> req high -> ack high -> req low -> ack low -> idle
    // a push outside idle is lost
    always_ff @(posedge clk_13p56_tmp or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (push) begin
                        state <= ST_WAIT_ACK_HI;
                    end
                end
                ST_WAIT_ACK_HI: begin
                    if (ack) begin
                        state <= ST_WAIT_ACK_LO;
                    end
                end
                ST_WAIT_ACK_LO: begin
                    if (!ack) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    assign req = (state == ST_WAIT_ACK_HI);

    // data captured once per item, stays put until ack falls
    always_ff @(posedge clk_13p56_tmp) begin
        if ((state == ST_IDLE) && push) begin
            data <= push_data;
        end
    end

endmodule

//--- source/iso14443_pkg.sv
package iso14443_pkg;

    // ==============================
    // miller symbols
    // ==============================

    // sequences X, Y, Z of modified miller coding, plus a bad pause position
    typedef enum logic [1:0] {
        SYM_X,
        SYM_Y,
        SYM_Z,
        SYM_ERR
    } miller_sym_e;

    // one-cycle strobe from the symbol detector
    typedef struct packed {
        logic        valid;
        miller_sym_e kind;
    } miller_sym_t;

    // ==============================
    // decoded items
    // ==============================

    typedef enum logic [1:0] {
        RX_SOF,
        RX_BIT,
        RX_EOF,
        RX_ERR
    } rx_kind_e;

    // value only means something for RX_BIT
    typedef struct packed {
        rx_kind_e kind;
        logic     value;
    } rx_item_t;

    // ==============================
    // field events
    // ==============================

    typedef enum logic {
        EVT_FIELD_LOST,
        EVT_FIELD_READY
    } field_evt_e;

    typedef struct packed {
        field_evt_e evt;
    } field_evt_t;

endpackage

//--- source/miller_frame_decode.sv
`timescale 1ns/1ns

module miller_frame_decode import iso14443_pkg::*; (
    input  logic        clk_13p56_tmp,
    input  logic        card_rst_n,
    input  miller_sym_t sym,
    output logic        item_push,
    output rx_item_t    item
);

    logic     in_frame;
    // a decoded bit waits one symbol, the closing 0 never leaves
    logic     held_valid;
    // last decoded bit, also picks the meaning of the next Z or Y
    logic     held_bit;
    logic     in_frame_nxt;
    logic     held_valid_nxt;
    logic     held_bit_nxt;
    logic     push_nxt;
    rx_item_t item_nxt;

    // ==============================
    // symbol to item mapping
    // ==============================

    always_comb begin
        in_frame_nxt   = in_frame;
        held_valid_nxt = held_valid;
        held_bit_nxt   = held_bit;
        push_nxt       = 1'b0;
        // most pushes release the held bit
        item_nxt       = '{kind: RX_BIT, value: held_bit};

        if (sym.valid) begin
            if (!in_frame) begin
                // outside a frame only a Z means anything
                if (sym.kind == SYM_Z) begin
                    in_frame_nxt   = 1'b1;
                    held_valid_nxt = 1'b0;
                    // start of communication counts as a 0
                    held_bit_nxt   = 1'b0;
                    push_nxt       = 1'b1;
                    item_nxt       = '{kind: RX_SOF, value: 1'b0};
                end
            end else begin
                case (sym.kind)
                    SYM_X: begin
                        push_nxt       = held_valid;
                        held_valid_nxt = 1'b1;
                        held_bit_nxt   = 1'b1;
                    end
                    SYM_Z: begin
                        if (held_bit) begin
                            // Z right after X is not allowed
                            in_frame_nxt = 1'b0;
                            push_nxt     = 1'b1;
                            item_nxt     = '{kind: RX_ERR, value: 1'b0};
                        end else begin
                            push_nxt       = held_valid;
                            held_valid_nxt = 1'b1;
                            held_bit_nxt   = 1'b0;
                        end
                    end
                    SYM_Y: begin
                        if (held_bit) begin
                            // 0 after a 1 is sent as Y
                            push_nxt       = held_valid;
                            held_valid_nxt = 1'b1;
                            held_bit_nxt   = 1'b0;
                        end else begin
                            // 0 then Y, end of frame eats the 0
                            in_frame_nxt = 1'b0;
                            push_nxt     = 1'b1;
                            item_nxt     = '{kind: RX_EOF, value: 1'b0};
                        end
                    end
                    default: begin
                        in_frame_nxt = 1'b0;
                        push_nxt     = 1'b1;
                        item_nxt     = '{kind: RX_ERR, value: 1'b0};
                    end
                endcase
            end
        end
    end

    // ==============================
    // registers
    // ==============================

    always_ff @(posedge clk_13p56_tmp or negedge card_rst_n) begin
        if (!card_rst_n) begin
            in_frame   <= 1'b0;
            held_valid <= 1'b0;
            held_bit   <= 1'b0;
            item_push  <= 1'b0;
        end else begin
            in_frame   <= in_frame_nxt;
            held_valid <= held_valid_nxt;
            held_bit   <= held_bit_nxt;
            item_push  <= push_nxt;
        end
    end

    // item only read while item_push is high
    always_ff @(posedge clk_13p56_tmp) begin
        item <= item_nxt;
    end

endmodule

//--- source/miller_symbol_detect.sv
`timescale 1ns/1ns

`include "iso14443_consts.svh"

module miller_symbol_detect import iso14443_pkg::*; (
    input  logic        clk_13p56_tmp,
    input  logic        card_rst_n,
    input  logic        pause_sync,
    output miller_sym_t sym
);

    localparam int TICK_W = $clog2(`ISO_BIT_TICKS);
    localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(`ISO_BIT_TICKS - 1);

    logic              pause_prev;
    logic              fall;
    // in a frame, window grid running
    logic              active;
    // the window that carried the start of communication
    logic              soc_window;
    logic [TICK_W-1:0] tick;
    logic              pause_seen;
    logic [TICK_W-1:0] pause_off;
    logic              prev_y;
    logic              cur_seen;
    logic [TICK_W-1:0] cur_off;
    miller_sym_e       win_sym;

    assign fall = pause_prev && !pause_sync;

    // ==============================
    // window classification
    // ==============================

    // a pause falling on the last tick still counts for this window
    assign cur_seen = pause_seen || fall;
    assign cur_off  = pause_seen ? pause_off : tick;

    always_comb begin
        if (!cur_seen) begin
            // no pause at all
            win_sym = SYM_Y;
        end else if (cur_off <= TICK_W'(`ISO_Z_WIN_MAX)) begin
            win_sym = SYM_Z;
        end else if ((cur_off >= TICK_W'(`ISO_X_WIN_MIN)) &&
                     (cur_off <= TICK_W'(`ISO_X_WIN_MAX))) begin
            win_sym = SYM_X;
        end else begin
            // pause between the legal ranges
            win_sym = SYM_ERR;
        end
    end

    // ==============================
    // window grid
    // ==============================

    always_ff @(posedge clk_13p56_tmp or negedge card_rst_n) begin
        if (!card_rst_n) begin
            pause_prev <= 1'b1;
            active     <= 1'b0;
            soc_window <= 1'b0;
            tick       <= '0;
            pause_seen <= 1'b0;
            pause_off  <= '0;
            prev_y     <= 1'b0;
            sym        <= '{valid: 1'b0, kind: SYM_X};
        end else begin
            pause_prev <= pause_sync;
            // strobe, low unless set below
            sym        <= '{valid: 1'b0, kind: SYM_X};

            if (!active) begin
                // first pause of a frame is the start of communication
                if (fall) begin
                    active     <= 1'b1;
                    soc_window <= 1'b1;
                    // the edge cycle itself is offset 0
                    tick       <= TICK_W'(1);
                    pause_seen <= 1'b0;
                    prev_y     <= 1'b0;
                    sym        <= '{valid: 1'b1, kind: SYM_Z};
                end
            end else begin
                tick <= tick + TICK_W'(1);

                // only the first pause in a window sets its offset
                if (fall && !pause_seen) begin
                    pause_seen <= 1'b1;
                    pause_off  <= tick;
                end

                if (tick == LAST_TICK) begin
                    pause_seen <= 1'b0;
                    if (soc_window) begin
                        // Z already sent at the edge
                        soc_window <= 1'b0;
                    end else begin
                        sym    <= '{valid: 1'b1, kind: win_sym};
                        prev_y <= (win_sym == SYM_Y);
                        // two Y in a row is idle carrier, ERR aborts
                        if ((win_sym == SYM_ERR) || ((win_sym == SYM_Y) && prev_y)) begin
                            active <= 1'b0;
                        end
                    end
                end
            end
        end
    end

endmodule

//--- source/nfc_emulation_top.sv
`timescale 1ns/1ns

module nfc_emulation_top import iso14443_pkg::*; (
    input  logic       clk_13p56_tmp,
    input  logic       rst_n,
    input  logic       pause_n,
    input  logic       clk_locked,
    output logic       clk_13p56_en,
    output logic       card_rst_n,
    output logic       rx_req,
    input  logic       rx_ack,
    output rx_item_t   rx_data,
    output logic       evt_req,
    input  logic       evt_ack,
    output field_evt_t evt_data
);

    logic        pause_sync;
    logic        evt_push;
    field_evt_t  evt_item;
    miller_sym_t sym;
    logic        item_push;
    rx_item_t    item;

    // ==============================
    // field and reset supervision
    // ==============================

    // runs on rst_n so it keeps going while the card is held in reset
    field_reset_ctrl u_field_reset_ctrl (
        .clk_13p56_tmp (clk_13p56_tmp),
        .rst_n         (rst_n),
        .pause_n       (pause_n),
        .clk_locked    (clk_locked),
        .pause_sync    (pause_sync),
        .clk_13p56_en  (clk_13p56_en),
        .card_rst_n    (card_rst_n),
        .evt_push      (evt_push),
        .evt_data      (evt_item)
    );

    // ==============================
    // reader to card decode
    // ==============================

    miller_symbol_detect u_symbol_detect (
        .clk_13p56_tmp (clk_13p56_tmp),
        .card_rst_n    (card_rst_n),
        .pause_sync    (pause_sync),
        .sym           (sym)
    );

    miller_frame_decode u_frame_decode (
        .clk_13p56_tmp (clk_13p56_tmp),
        .card_rst_n    (card_rst_n),
        .sym           (sym),
        .item_push     (item_push),
        .item          (item)
    );

    // ==============================
    // output channels
    // ==============================

    // decoded items, cleared along with the card logic
    four_phase_tx #(
        .payload_t (rx_item_t)
    ) u_rx_tx (
        .clk_13p56_tmp (clk_13p56_tmp),
        .rst_n         (card_rst_n),
        .push          (item_push),
        .push_data     (item),
        .req           (rx_req),
        .ack           (rx_ack),
        .data          (rx_data)
    );

    // field events must survive card reset
    four_phase_tx #(
        .payload_t (field_evt_t)
    ) u_evt_tx (
        .clk_13p56_tmp (clk_13p56_tmp),
        .rst_n         (rst_n),
        .push          (evt_push),
        .push_data     (evt_item),
        .req           (evt_req),
        .ack           (evt_ack),
        .data          (evt_data)
    );

endmodule
